// ==== hdl/dma_pkg.sv ====
// ************************************************
// Shared types, register map and backend states
// of the DMA engine. Modules take it with a
// wildcard import in their body.
// ************************************************

`default_nettype none

package dma_pkg;

  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned TID_WIDTH  = 32;
  localparam int unsigned REG_ADDR_WIDTH = 3;

  // Word addresses, no byte offset bits
  typedef logic [ADDR_WIDTH-1:0]     addr_t;
  typedef logic [DATA_WIDTH-1:0]     data_t;
  typedef logic [ADDR_WIDTH-1:0]     len_t;
  typedef logic [TID_WIDTH-1:0]      tid_t;
  typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

  // Register map of the front end
  localparam reg_addr_t REG_SRC     = 3'd0;
  localparam reg_addr_t REG_DST     = 3'd1;
  localparam reg_addr_t REG_LEN     = 3'd2;
  // Bit 0 is busy
  localparam reg_addr_t REG_STATUS  = 3'd3;
  localparam reg_addr_t REG_NEXT_ID = 3'd4;
  localparam reg_addr_t REG_DONE_ID = 3'd5;

  // Copy engine states
  typedef enum logic [1:0] {
    BE_IDLE  = 2'd0,
    BE_COPY  = 2'd1,
    BE_DRAIN = 2'd2
  } be_state_t;

endpackage

`default_nettype wire

// ==== hdl/dma_reg_frontend.sv ====
// ************************************************
// Register front end of the DMA engine. Holds the
// job registers, launches a job on a NEXT_ID read
// and counts finished jobs in DONE_ID. Read data
// returns one cycle after the read strobe.
// ************************************************

`timescale 1ns/100ps
`default_nettype none

module dma_reg_frontend (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               reg_wr_i,
  input  logic               reg_rd_i,
  input  dma_pkg::reg_addr_t reg_addr_i,
  input  dma_pkg::data_t     reg_wdata_i,
  input  logic               queue_full_i,
  input  logic               queue_empty_i,
  input  logic               backend_idle_i,
  input  logic               job_done_i,
  output dma_pkg::data_t     reg_rdata_o,
  output logic               reg_rvalid_o,
  output logic               job_push_o,
  output dma_pkg::addr_t     job_src_o,
  output dma_pkg::addr_t     job_dst_o,
  output dma_pkg::len_t      job_len_o
);
  import dma_pkg::*;

  addr_t src_q;
  addr_t dst_q;
  len_t  len_q;
  tid_t  id_q;
  tid_t  id_next;
  tid_t  done_id_q;
  data_t rdata_d;
  data_t rdata_q;
  logic  rvalid_q;
  logic  launch_rd;
  logic  busy;

  // Ids skip zero, which marks a refused launch
  function automatic tid_t tid_incr(tid_t id);
    return (id == '1) ? tid_t'(1) : id + tid_t'(1);
  endfunction

  assign launch_rd = reg_rd_i && (reg_addr_i == REG_NEXT_ID);
  // Refuse zero length or a full queue
  assign job_push_o = launch_rd && (len_q != '0) && !queue_full_i;
  assign id_next    = tid_incr(id_q);
  assign busy       = !queue_empty_i || !backend_idle_i;

  assign job_src_o    = src_q;
  assign job_dst_o    = dst_q;
  assign job_len_o    = len_q;
  assign reg_rdata_o  = rdata_q;
  assign reg_rvalid_o = rvalid_q;

  always_comb begin
    case (reg_addr_i)
      REG_SRC:     rdata_d = src_q;
      REG_DST:     rdata_d = dst_q;
      REG_LEN:     rdata_d = len_q;
      REG_STATUS:  rdata_d = {{(DATA_WIDTH-1){1'b0}}, busy};
      REG_NEXT_ID: rdata_d = job_push_o ? id_next : '0;
      REG_DONE_ID: rdata_d = done_id_q;
      default:     rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      src_q     <= '0;
      dst_q     <= '0;
      len_q     <= '0;
      id_q      <= '0;
      done_id_q <= '0;
      rvalid_q  <= 1'b0;
    end else begin
      if (reg_wr_i) begin
        case (reg_addr_i)
          REG_SRC: src_q <= reg_wdata_i;
          REG_DST: dst_q <= reg_wdata_i;
          REG_LEN: len_q <= reg_wdata_i;
          default: ;
        endcase
      end
      if (job_push_o) begin
        id_q <= id_next;
      end
      // Jobs complete in launch order
      if (job_done_i) begin
        done_id_q <= tid_incr(done_id_q);
      end
      rvalid_q <= reg_rd_i;
    end
  end

  // Read data register
  always_ff @(posedge clk_i) begin
    if (reg_rd_i) begin
      rdata_q <= rdata_d;
    end
  end

  // Every done strobe belongs to a job launched earlier
  a_done_after_launch: assert property (
    @(posedge clk_i) disable iff (reset_i) job_done_i |-> (done_id_q != id_q)
  ) else $error("job done reported with no launched job outstanding");

endmodule

`default_nettype wire

// ==== hdl/dma_job_queue.sv ====
// ************************************************
// Job FIFO between the register front end and the
// copy backend. Holds whole job descriptors, the
// head is visible while the queue is not empty.
// ************************************************

`timescale 1ns/100ps
`default_nettype none

module dma_job_queue #(
  parameter int unsigned QUEUE_DEPTH = 2
) (
  input  logic           clk_i,
  input  logic           reset_i,
  input  logic           push_i,
  input  dma_pkg::addr_t src_i,
  input  dma_pkg::addr_t dst_i,
  input  dma_pkg::len_t  len_i,
  input  logic           pop_i,
  output logic           full_o,
  output logic           empty_o,
  output dma_pkg::addr_t head_src_o,
  output dma_pkg::addr_t head_dst_o,
  output dma_pkg::len_t  head_len_o
);
  import dma_pkg::*;

  localparam int unsigned PTR_WIDTH = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int unsigned CNT_WIDTH = $clog2(QUEUE_DEPTH + 1);

  typedef logic [PTR_WIDTH-1:0] ptr_t;
  typedef logic [CNT_WIDTH-1:0] cnt_t;

  addr_t src_mem [QUEUE_DEPTH];
  addr_t dst_mem [QUEUE_DEPTH];
  len_t  len_mem [QUEUE_DEPTH];
  ptr_t  wr_ptr_q;
  ptr_t  rd_ptr_q;
  cnt_t  count_q;

  // Wrap at the depth, also works for a depth of one
  function automatic ptr_t ptr_incr(ptr_t ptr);
    return (ptr == ptr_t'(QUEUE_DEPTH - 1)) ? '0 : ptr + ptr_t'(1);
  endfunction

  assign empty_o    = (count_q == '0);
  assign full_o     = (count_q == cnt_t'(QUEUE_DEPTH));
  assign head_src_o = src_mem[rd_ptr_q];
  assign head_dst_o = dst_mem[rd_ptr_q];
  assign head_len_o = len_mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_incr(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_incr(rd_ptr_q);
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + cnt_t'(1);
        2'b01:   count_q <= count_q - cnt_t'(1);
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      src_mem[wr_ptr_q] <= src_i;
      dst_mem[wr_ptr_q] <= dst_i;
      len_mem[wr_ptr_q] <= len_i;
    end
  end

  a_no_pop_when_empty: assert property (
    @(posedge clk_i) disable iff (reset_i) pop_i |-> !empty_o
  ) else $error("pop from an empty job queue");

  a_no_push_when_full: assert property (
    @(posedge clk_i) disable iff (reset_i) push_i |-> !full_o
  ) else $error("push into a full job queue");

endmodule

`default_nettype wire

// ==== hdl/dma_backend.sv ====
// ************************************************
// Copy engine of the DMA. Pops a job, issues one
// word read per cycle and writes each word two
// cycles after its read. done_o pulses one cycle
// after the last write of a job.
// ************************************************

`timescale 1ns/100ps
`default_nettype none

module dma_backend (
  input  logic           clk_i,
  input  logic           reset_i,
  input  logic           job_empty_i,
  input  dma_pkg::addr_t job_src_i,
  input  dma_pkg::addr_t job_dst_i,
  input  dma_pkg::len_t  job_len_i,
  input  dma_pkg::data_t mem_rdata_i,
  output logic           job_pop_o,
  output logic           idle_o,
  output logic           done_o,
  output logic           mem_rd_o,
  output dma_pkg::addr_t mem_raddr_o,
  output logic           mem_wr_o,
  output dma_pkg::addr_t mem_waddr_o,
  output dma_pkg::data_t mem_wdata_o
);
  import dma_pkg::*;

  be_state_t  state_q;
  be_state_t  state_d;
  addr_t      rd_addr_q;
  addr_t      wr_addr_q;
  len_t       rd_left_q;
  addr_t      issue_waddr;
  logic       issue_last;
  logic [1:0] issue_tag;
  logic [1:0] tag_q;
  logic       in_flight;
  // Write pipeline, stage 1 waits for read data, stage 2 writes
  logic       s1_valid_q;
  logic       s1_last_q;
  addr_t      s1_addr_q;
  logic [1:0] s1_tag_q;
  logic       s2_valid_q;
  logic       s2_last_q;
  addr_t      s2_addr_q;
  logic [1:0] s2_tag_q;
  data_t      wdata_q;
  logic       done_q;
  logic [1:0] done_tag_q;

  // New job may start once the previous one has issued its last read
  assign job_pop_o   = (state_q != BE_COPY) && !job_empty_i;
  assign mem_rd_o    = job_pop_o || (state_q == BE_COPY);
  assign mem_raddr_o = job_pop_o ? job_src_i : rd_addr_q;
  assign issue_waddr = job_pop_o ? job_dst_i : wr_addr_q;
  assign issue_last  = job_pop_o ? (job_len_i == len_t'(1)) : (rd_left_q == len_t'(1));
  assign issue_tag   = job_pop_o ? tag_q + 2'd1 : tag_q;
  assign in_flight   = s1_valid_q || s2_valid_q;

  assign idle_o      = (state_q == BE_IDLE);
  assign done_o      = done_q;
  assign mem_wr_o    = s2_valid_q;
  assign mem_waddr_o = s2_addr_q;
  assign mem_wdata_o = wdata_q;

  always_comb begin
    state_d = state_q;
    if (job_pop_o) begin
      state_d = issue_last ? BE_DRAIN : BE_COPY;
    end else if ((state_q == BE_COPY) && issue_last) begin
      state_d = BE_DRAIN;
    end else if ((state_q == BE_DRAIN) && done_q && !in_flight) begin
      // DONE_ID has counted the job by the time idle shows
      state_d = BE_IDLE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q    <= BE_IDLE;
      tag_q      <= '0;
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
      done_q     <= 1'b0;
    end else begin
      state_q    <= state_d;
      s1_valid_q <= mem_rd_o;
      s2_valid_q <= s1_valid_q;
      done_q     <= s2_valid_q && s2_last_q;
      if (job_pop_o) begin
        tag_q <= issue_tag;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_rd_o) begin
      rd_addr_q <= mem_raddr_o + addr_t'(1);
      wr_addr_q <= issue_waddr + addr_t'(1);
      rd_left_q <= (job_pop_o ? job_len_i : rd_left_q) - len_t'(1);
    end
    s1_addr_q  <= issue_waddr;
    s1_last_q  <= issue_last;
    s1_tag_q   <= issue_tag;
    s2_addr_q  <= s1_addr_q;
    s2_last_q  <= s1_last_q;
    s2_tag_q   <= s1_tag_q;
    // Read data arrives one cycle after the read
    wdata_q    <= mem_rdata_i;
    done_tag_q <= s2_tag_q;
  end

  // A job finishes only after all of its reads have gone out
  a_done_after_reads: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (done_o && mem_rd_o) |-> (done_tag_q != issue_tag)
  ) else $error("done reported while the same job still reads");

endmodule

`default_nettype wire

// ==== hdl/dma_core_top.sv ====
// ************************************************
// Top level of the DMA engine. Joins the register
// front end, the job queue and the copy backend.
// QUEUE_DEPTH sets the number of pending jobs.
// ************************************************

`timescale 1ns/100ps
`default_nettype none

module dma_core_top #(
  parameter int unsigned QUEUE_DEPTH = 2
) (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               reg_wr_i,
  input  logic               reg_rd_i,
  input  dma_pkg::reg_addr_t reg_addr_i,
  input  dma_pkg::data_t     reg_wdata_i,
  input  dma_pkg::data_t     mem_rdata_i,
  output dma_pkg::data_t     reg_rdata_o,
  output logic               reg_rvalid_o,
  output logic               mem_rd_o,
  output dma_pkg::addr_t     mem_raddr_o,
  output logic               mem_wr_o,
  output dma_pkg::addr_t     mem_waddr_o,
  output dma_pkg::data_t     mem_wdata_o
);
  import dma_pkg::*;

  // Launch path
  logic  job_push;
  addr_t job_src;
  addr_t job_dst;
  len_t  job_len;
  logic  queue_full;
  logic  queue_empty;

  // Queue head towards the backend
  addr_t head_src;
  addr_t head_dst;
  len_t  head_len;
  logic  job_pop;

  logic  backend_idle;
  logic  job_done;

  dma_reg_frontend i_frontend (
    .clk_i          ( clk_i        ),
    .reset_i        ( reset_i      ),
    .reg_wr_i       ( reg_wr_i     ),
    .reg_rd_i       ( reg_rd_i     ),
    .reg_addr_i     ( reg_addr_i   ),
    .reg_wdata_i    ( reg_wdata_i  ),
    .queue_full_i   ( queue_full   ),
    .queue_empty_i  ( queue_empty  ),
    .backend_idle_i ( backend_idle ),
    .job_done_i     ( job_done     ),
    .reg_rdata_o    ( reg_rdata_o  ),
    .reg_rvalid_o   ( reg_rvalid_o ),
    .job_push_o     ( job_push     ),
    .job_src_o      ( job_src      ),
    .job_dst_o      ( job_dst      ),
    .job_len_o      ( job_len      )
  );

  dma_job_queue #(
    .QUEUE_DEPTH ( QUEUE_DEPTH )
  ) i_queue (
    .clk_i      ( clk_i       ),
    .reset_i    ( reset_i     ),
    .push_i     ( job_push    ),
    .src_i      ( job_src     ),
    .dst_i      ( job_dst     ),
    .len_i      ( job_len     ),
    .pop_i      ( job_pop     ),
    .full_o     ( queue_full  ),
    .empty_o    ( queue_empty ),
    .head_src_o ( head_src    ),
    .head_dst_o ( head_dst    ),
    .head_len_o ( head_len    )
  );

  dma_backend i_backend (
    .clk_i       ( clk_i        ),
    .reset_i     ( reset_i      ),
    .job_empty_i ( queue_empty  ),
    .job_src_i   ( head_src     ),
    .job_dst_i   ( head_dst     ),
    .job_len_i   ( head_len     ),
    .mem_rdata_i ( mem_rdata_i  ),
    .job_pop_o   ( job_pop      ),
    .idle_o      ( backend_idle ),
    .done_o      ( job_done     ),
    .mem_rd_o    ( mem_rd_o     ),
    .mem_raddr_o ( mem_raddr_o  ),
    .mem_wr_o    ( mem_wr_o     ),
    .mem_waddr_o ( mem_waddr_o  ),
    .mem_wdata_o ( mem_wdata_o  )
  );

endmodule

`default_nettype wire

// ==== bench/tb_dma_core_top.sv ====
// **************************************************
// Testbench for the DMA core. Drives the register
// bus with LFSR stimulus, models the memory and a
// reference copy of it, and checks ids, DONE_ID,
// busy, write timing and the copied data.
// **************************************************

`timescale 1ns/100ps
`default_nettype none

module tb_dma_core_top;
  import dma_pkg::*;

  localparam int QUEUE_DEPTH = 2;
  localparam int CLK_PERIOD  = 40;
  localparam int DRIVE_DELAY = 2;
  localparam int MEM_AW      = 10;
  localparam int MEM_WORDS   = 1 << MEM_AW;
  // Upper half of the model memory takes the destinations
  localparam int DST_BASE    = MEM_WORDS / 2;
  localparam int NUM_RANDOM  = 50;
  localparam int NUM_JOBS    = NUM_RANDOM + 2 * QUEUE_DEPTH + 8;
  localparam int MAX_LEN     = 5 * QUEUE_DEPTH + 16;
  localparam int SLACK       = 4;
  localparam int WATCHDOG_CYCLES = NUM_JOBS * MAX_LEN * QUEUE_DEPTH * SLACK;

  logic      clk;
  logic      reset;
  logic      reg_wr;
  logic      reg_rd;
  reg_addr_t reg_addr;
  data_t     reg_wdata;
  data_t     mem_rdata;
  data_t     reg_rdata;
  logic      reg_rvalid;
  logic      mem_rd;
  addr_t     mem_raddr;
  logic      mem_wr;
  addr_t     mem_waddr;
  data_t     mem_wdata;

  // Memory model, reference copy and allowed write targets
  data_t       mem     [MEM_WORDS];
  data_t       ref_mem [MEM_WORDS];
  bit          dst_mark [MEM_WORDS];
  logic        rd_pend;
  data_t       rd_data;
  int          wr_count;
  int          cycle_cnt = 0;
  int          rd_strobe_cycle;
  int          launch_cycle;
  int          first_wr_cycle;
  tid_t        next_id;
  tid_t        last_id;
  logic [31:0] lfsr_state;

  dma_core_top #(
    .QUEUE_DEPTH ( QUEUE_DEPTH )
  ) dma_core_top_inst (
    .clk_i        ( clk        ),
    .reset_i      ( reset      ),
    .reg_wr_i     ( reg_wr     ),
    .reg_rd_i     ( reg_rd     ),
    .reg_addr_i   ( reg_addr   ),
    .reg_wdata_i  ( reg_wdata  ),
    .mem_rdata_i  ( mem_rdata  ),
    .reg_rdata_o  ( reg_rdata  ),
    .reg_rvalid_o ( reg_rvalid ),
    .mem_rd_o     ( mem_rd     ),
    .mem_raddr_o  ( mem_raddr  ),
    .mem_wr_o     ( mem_wr     ),
    .mem_waddr_o  ( mem_waddr  ),
    .mem_wdata_o  ( mem_wdata  )
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) cycle_cnt = cycle_cnt + 1;

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      fail_now($sformatf("[FAIL] %s: got %h, expected %h", name, got, exp));
    end
  endtask

  // Memory requests are sampled mid-cycle
  always @(negedge clk) begin
    rd_pend = 1'b0;
    if (!reset && mem_rd) begin
      if (mem_raddr >= addr_t'(MEM_WORDS)) begin
        fail_now($sformatf("read from address %h outside the model memory", mem_raddr));
      end
      rd_data = mem[mem_raddr[MEM_AW-1:0]];
      rd_pend = 1'b1;
    end
    if (!reset && mem_wr) begin
      if (mem_waddr >= addr_t'(MEM_WORDS) || !dst_mark[mem_waddr[MEM_AW-1:0]]) begin
        fail_now($sformatf("write to address %h outside any destination range", mem_waddr));
      end
      mem[mem_waddr[MEM_AW-1:0]] = mem_wdata;
      wr_count = wr_count + 1;
      if (first_wr_cycle < 0) begin
        first_wr_cycle = cycle_cnt;
      end
    end
  end

  // Read data is valid in the cycle after the read
  always @(posedge clk) begin
    #DRIVE_DELAY;
    mem_rdata = rd_pend ? rd_data : '0;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic addr_t pick_src();
    return addr_t'(rand_bits(32) % 32'(DST_BASE - MAX_LEN));
  endfunction

  function automatic addr_t pick_dst();
    return addr_t'(DST_BASE) + addr_t'(rand_bits(32) % 32'(DST_BASE - MAX_LEN));
  endfunction

  // Tasks start and end a few ns after a rising edge
  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #DRIVE_DELAY;
    end
  endtask

  task automatic write_reg(input reg_addr_t addr, input data_t data);
    reg_wr    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(posedge clk);
    #DRIVE_DELAY;
    reg_wr = 1'b0;
  endtask

  task automatic read_reg(input reg_addr_t addr, output data_t data);
    reg_rd   = 1'b1;
    reg_addr = addr;
    @(negedge clk);
    rd_strobe_cycle = cycle_cnt;
    compare("reg_rvalid_o", 32'(reg_rvalid), 32'h0);
    @(posedge clk);
    #DRIVE_DELAY;
    reg_rd = 1'b0;
    @(negedge clk);
    compare("reg_rvalid_o", 32'(reg_rvalid), 32'h1);
    data = reg_rdata;
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic launch_job(input addr_t src, input addr_t dst, input len_t len,
                            output tid_t id);
    addr_t a;
    data_t d;
    for (int k = 0; k < int'(len); k++) begin
      a = dst + addr_t'(k);
      dst_mark[a[MEM_AW-1:0]] = 1'b1;
    end
    write_reg(REG_SRC, src);
    write_reg(REG_DST, dst);
    write_reg(REG_LEN, len);
    read_reg(REG_NEXT_ID, d);
    launch_cycle = rd_strobe_cycle;
    id = d;
  endtask

  // Id model and reference copy of an accepted job
  task automatic expect_accept(input addr_t src, input addr_t dst, input len_t len,
                               input tid_t id);
    addr_t s;
    addr_t d;
    compare("NEXT_ID", id, next_id);
    for (int k = 0; k < int'(len); k++) begin
      s = src + addr_t'(k);
      d = dst + addr_t'(k);
      ref_mem[d[MEM_AW-1:0]] = ref_mem[s[MEM_AW-1:0]];
    end
    last_id = next_id;
    next_id = next_id + tid_t'(1);
  endtask

  task automatic drain_and_check();
    data_t d;
    d = 32'h1;
    while (d[0]) begin
      read_reg(REG_STATUS, d);
    end
    read_reg(REG_DONE_ID, d);
    compare("DONE_ID", d, last_id);
    for (int i = 0; i < MEM_WORDS; i++) begin
      compare($sformatf("mem[%0h]", i), mem[i[MEM_AW-1:0]], ref_mem[i[MEM_AW-1:0]]);
      dst_mark[i[MEM_AW-1:0]] = 1'b0;
    end
  endtask

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    fail_now($sformatf("timeout after %0d clock cycles, the DMA did not finish",
                       WATCHDOG_CYCLES));
  end

  initial begin : main
    data_t d;
    tid_t  id;
    addr_t src;
    addr_t dst;
    len_t  len;
    int    gap;
    int    writes_before;
    data_t vals [3];

    reset          = 1'b1;
    reg_wr         = 1'b0;
    reg_rd         = 1'b0;
    reg_addr       = '0;
    reg_wdata      = '0;
    mem_rdata      = '0;
    rd_pend        = 1'b0;
    rd_data        = '0;
    wr_count       = 0;
    first_wr_cycle = -1;
    next_id        = tid_t'(1);
    last_id        = '0;
    lfsr_state     = 32'h2e78;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i[MEM_AW-1:0]]      = (i < DST_BASE) ? rand_bits(32) : ~32'(i);
      ref_mem[i[MEM_AW-1:0]]  = mem[i[MEM_AW-1:0]];
      dst_mark[i[MEM_AW-1:0]] = 1'b0;
    end

    repeat (3) @(posedge clk);
    #DRIVE_DELAY;
    reset = 1'b0;
    compare("mem_rd_o", 32'(mem_rd), 32'h0);
    compare("mem_wr_o", 32'(mem_wr), 32'h0);
    compare("reg_rvalid_o", 32'(reg_rvalid), 32'h0);
    read_reg(REG_STATUS, d);
    compare("STATUS", d, 32'h0);
    read_reg(REG_DONE_ID, d);
    compare("DONE_ID", d, 32'h0);

    // Register write and read back
    for (int k = 0; k < 3; k++) begin
      vals[k] = rand_bits(32);
      write_reg(reg_addr_t'(k), vals[k]);
    end
    for (int k = 0; k < 3; k++) begin
      read_reg(reg_addr_t'(k), d);
      compare($sformatf("register %0d", k), d, vals[k]);
    end
    read_reg(reg_addr_t'(6), d);
    compare("register 6", d, 32'h0);
    read_reg(reg_addr_t'(7), d);
    compare("register 7", d, 32'h0);

    // Single copy with write latency
    src = pick_src();
    dst = pick_dst();
    len = len_t'(rand_bits(4)) + len_t'(1);
    first_wr_cycle = -1;
    launch_job(src, dst, len, id);
    expect_accept(src, dst, len, id);
    read_reg(REG_STATUS, d);
    compare("STATUS busy", 32'(d[0]), 32'h1);
    drain_and_check();
    compare("first write latency", 32'(first_wr_cycle - launch_cycle), 32'd3);

    // Zero length is refused, then ids keep counting
    writes_before = wr_count;
    write_reg(REG_LEN, '0);
    read_reg(REG_NEXT_ID, d);
    compare("NEXT_ID", d, 32'h0);
    idle_cycles(8);
    compare("write count", 32'(wr_count), 32'(writes_before));
    read_reg(REG_STATUS, d);
    compare("STATUS busy", 32'(d[0]), 32'h0);
    for (int k = 0; k < 3; k++) begin
      src = pick_src();
      dst = pick_dst();
      len = len_t'(rand_bits(2)) + len_t'(1);
      launch_job(src, dst, len, id);
      expect_accept(src, dst, len, id);
    end
    drain_and_check();

    // Fill the queue behind a long job, one launch more is refused
    len = len_t'(MAX_LEN);
    for (int j = 0; j <= QUEUE_DEPTH; j++) begin
      src = addr_t'(j * MAX_LEN);
      dst = addr_t'(DST_BASE + j * MAX_LEN);
      launch_job(src, dst, len, id);
      expect_accept(src, dst, len, id);
    end
    launch_job(addr_t'((QUEUE_DEPTH + 1) * MAX_LEN),
               addr_t'(DST_BASE + (QUEUE_DEPTH + 1) * MAX_LEN), len, id);
    compare("NEXT_ID", id, 32'h0);
    read_reg(REG_STATUS, d);
    compare("STATUS busy", 32'(d[0]), 32'h1);
    drain_and_check();

    // Random jobs with random gaps, a refused launch is retried
    for (int n = 0; n < NUM_RANDOM; n++) begin
      src = pick_src();
      dst = pick_dst();
      len = len_t'(rand_bits(4)) + len_t'(1);
      launch_job(src, dst, len, id);
      while (id == '0) begin
        idle_cycles(1);
        read_reg(REG_NEXT_ID, d);
        id = d;
      end
      expect_accept(src, dst, len, id);
      gap = int'(rand_bits(3));
      idle_cycles(gap);
    end
    drain_and_check();

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
hdl/dma_pkg.sv
hdl/dma_reg_frontend.sv
hdl/dma_job_queue.sv
hdl/dma_backend.sv
hdl/dma_core_top.sv
bench/tb_dma_core_top.sv

// ==== Makefile ====
# Verilator build and run of the DMA core testbench

VERILATOR  ?= verilator
TOP        ?= tb_dma_core_top
RTL_TOP    ?= dma_core_top
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= -Wall
RTL_SRCS   ?= $(filter hdl/%,$(shell cat $(FILELIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "TESTS PASSED" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
